/* common/rob_consts.svh */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

//////////////////////////////
// rob sizing
//////////////////////////////

// slot 0 is the null tag so only ROB_SZ-1 slots hold instructions
`define ROB_SZ          32
`define ROB_TAG_BITS    5

//////////////////////////////
// architectural state
//////////////////////////////

`define ARCH_REGS       32
// x0 is hardwired to zero
`define ZERO_REG        5'd0

//////////////////////////////
// rv32 major opcodes
//////////////////////////////

`define OPCODE_BITS     7

`define RV32_LOAD       7'b0000011
`define RV32_STORE      7'b0100011
`define RV32_OP_IMM     7'b0010011
`define RV32_OP         7'b0110011
`define RV32_JAL_OP     7'b1101111
`define RV32_JALR_OP    7'b1100111
`define RV32_LUI_OP     7'b0110111
`define RV32_AUIPC_OP   7'b0010111
// conditional branches, predicted not taken
`define RV32_BRANCH     7'b1100011

`endif

/* common/ooo_pkg.sv */
`include "rob_consts.svh"

package ooo_pkg;

    //////////////////////////////
    // basic field types
    //////////////////////////////

    // rob tag, zero means no tag
    typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;

    // architectural register index
    typedef logic [$clog2(`ARCH_REGS)-1:0] reg_idx_t;

    // data word
    typedef logic [31:0] word_t;

    //////////////////////////////
    // enums
    //////////////////////////////

    // lifecycle of one rob slot
    typedef enum logic [1:0] {
        EMPTY,
        BUSY,
        READY
    } rob_state_t;

    // major opcodes seen at commit
    typedef enum logic [`OPCODE_BITS-1:0] {
        OPC_LOAD   = `RV32_LOAD,
        OPC_STORE  = `RV32_STORE,
        OPC_OP_IMM = `RV32_OP_IMM,
        OPC_OP     = `RV32_OP,
        OPC_JAL    = `RV32_JAL_OP,
        OPC_JALR   = `RV32_JALR_OP,
        OPC_LUI    = `RV32_LUI_OP,
        OPC_AUIPC  = `RV32_AUIPC_OP,
        OPC_BRANCH = `RV32_BRANCH
    } rv32_opcode_t;

    //////////////////////////////
    // packets
    //////////////////////////////

    // dispatch request into the rob
    typedef struct packed {
        logic         valid;
        rv32_opcode_t opcode;
        reg_idx_t     dest_reg;
        logic         is_branch;
    } dispatch_rob_packet_t;

    // allocation answer back to dispatch
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } rob_dispatch_packet_t;

    // result broadcast from the cdb
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_rob_packet_t;

    // head slot as seen by retire
    typedef struct packed {
        logic         valid;
        logic         ready;
        rob_tag_t     tag;
        rv32_opcode_t opcode;
        reg_idx_t     dest_reg;
        logic         is_branch;
        word_t        value;
    } rob_head_packet_t;

    // commit output, all zero when not valid
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t dest_reg;
        logic     reg_valid;
        word_t    value;
        logic     mem_valid;
        word_t    mem_addr;
        logic     is_branch;
        logic     flush;
    } rob_retire_packet_t;

endpackage

/* rob/reorder_buffer.sv */
`timescale 1ns/10ps

`include "rob_consts.svh"

module reorder_buffer (
    input  logic                         clock,
    input  logic                         reset,

    // dispatch side
    input  ooo_pkg::dispatch_rob_packet_t dispatch_in,
    output ooo_pkg::rob_dispatch_packet_t dispatch_out,

    // result writeback
    input  ooo_pkg::cdb_rob_packet_t      cdb_in,

    // reservation station operand reads
    input  logic                         rs_read1,
    input  ooo_pkg::rob_tag_t            rs_tag1,
    input  logic                         rs_read2,
    input  ooo_pkg::rob_tag_t            rs_tag2,
    output ooo_pkg::word_t               rs_value1,
    output ooo_pkg::word_t               rs_value2,

    // retire side
    input  logic                         commit,
    input  logic                         flush,
    output ooo_pkg::rob_head_packet_t     head,

    // occupancy
    output logic                         rob_full,
    output logic                         rob_empty
);

    //////////////////////////////
    // storage
    //////////////////////////////

    // per slot status, cleared on reset
    ooo_pkg::rob_state_t   state    [`ROB_SZ];

    // per slot payload
    ooo_pkg::word_t        value_q  [`ROB_SZ];
    ooo_pkg::rv32_opcode_t opcode_q [`ROB_SZ];
    ooo_pkg::reg_idx_t     dest_q   [`ROB_SZ];
    logic                  branch_q [`ROB_SZ];

    // oldest and next free slot
    ooo_pkg::rob_tag_t head_ptr;
    ooo_pkg::rob_tag_t tail_ptr;

    // live entries, 0 to ROB_SZ-1
    logic [`ROB_TAG_BITS:0] count;

    // accepted dispatch this cycle
    logic alloc;

    // pointer step that never lands on tag 0
    function automatic ooo_pkg::rob_tag_t next_ptr(input ooo_pkg::rob_tag_t ptr);
        if (ptr == ooo_pkg::rob_tag_t'(`ROB_SZ - 1)) begin
            return ooo_pkg::rob_tag_t'(1);
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////
    // status and allocation
    //////////////////////////////

    assign rob_empty = (count == '0);

    // slot 0 is never used so capacity is one short
    // flush also blocks dispatch for its cycle
    assign rob_full = (count == (`ROB_SZ - 1)) || flush;

    assign alloc = dispatch_in.valid && !rob_full;

    always_comb begin
        dispatch_out       = '0;
        dispatch_out.valid = alloc;
        // tag offered is the current tail
        dispatch_out.tag   = tail_ptr;
    end

    //////////////////////////////
    // head view and forwarding
    //////////////////////////////

    always_comb begin
        head           = '0;
        head.valid     = (state[head_ptr] != ooo_pkg::EMPTY);
        head.ready     = (state[head_ptr] == ooo_pkg::READY);
        head.tag       = head_ptr;
        head.opcode    = opcode_q[head_ptr];
        head.dest_reg  = dest_q[head_ptr];
        head.is_branch = branch_q[head_ptr];
        head.value     = value_q[head_ptr];
    end

    // operand forwarding, zero when not requested
    assign rs_value1 = rs_read1 ? value_q[rs_tag1] : '0;
    assign rs_value2 = rs_read2 ? value_q[rs_tag2] : '0;

    //////////////////////////////
    // control state
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ROB_SZ; i++) begin
                state[i] <= ooo_pkg::EMPTY;
            end
            head_ptr <= ooo_pkg::rob_tag_t'(1);
            tail_ptr <= ooo_pkg::rob_tag_t'(1);
            count    <= '0;
        end else begin
            // new instruction waits for its result
            if (alloc) begin
                state[tail_ptr] <= ooo_pkg::BUSY;
                tail_ptr        <= next_ptr(tail_ptr);
            end

            // result arrived
            if (cdb_in.valid) begin
                state[cdb_in.tag] <= ooo_pkg::READY;
            end

            if (flush) begin
                // mispredicted branch retires and takes every younger slot with it
                for (int i = 0; i < `ROB_SZ; i++) begin
                    state[i] <= ooo_pkg::EMPTY;
                end
                head_ptr <= tail_ptr;
                count    <= '0;
            end else begin
                // normal in-order commit of the head
                if (commit) begin
                    state[head_ptr] <= ooo_pkg::EMPTY;
                    head_ptr        <= next_ptr(head_ptr);
                end

                case ({alloc, commit})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            opcode_q[tail_ptr] <= dispatch_in.opcode;
            dest_q[tail_ptr]   <= dispatch_in.dest_reg;
            branch_q[tail_ptr] <= dispatch_in.is_branch;
            // stale value from an older occupant is dropped
            value_q[tail_ptr]  <= '0;
        end

        // stores bring their address, branches their taken flag
        if (cdb_in.valid) begin
            value_q[cdb_in.tag] <= cdb_in.value;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // cdb only completes live, allocated entries
    a_cdb_live_tag: assert property (
        @(posedge clock) disable iff (reset)
        cdb_in.valid |-> (cdb_in.tag != '0) && (state[cdb_in.tag] != ooo_pkg::EMPTY)
    );

    // retire control only commits a completed head
    a_commit_ready: assert property (
        @(posedge clock) disable iff (reset)
        commit |-> (state[head_ptr] == ooo_pkg::READY)
    );

endmodule

/* design/retire_control.sv */
`timescale 1ns/10ps

`include "rob_consts.svh"

module retire_control (
    input  ooo_pkg::rob_head_packet_t   head,
    output logic                       commit,
    output logic                       flush,
    output ooo_pkg::rob_retire_packet_t retire_out
);

    // opcodes that update the register file
    function automatic logic writes_reg(input ooo_pkg::rv32_opcode_t op);
        case (op)
            ooo_pkg::OPC_LOAD,
            ooo_pkg::OPC_OP_IMM,
            ooo_pkg::OPC_OP,
            ooo_pkg::OPC_JAL,
            ooo_pkg::OPC_JALR,
            ooo_pkg::OPC_LUI,
            ooo_pkg::OPC_AUIPC: return 1'b1;
            default:            return 1'b0;
        endcase
    endfunction

    // only stores touch memory
    function automatic logic writes_mem(input ooo_pkg::rv32_opcode_t op);
        return (op == ooo_pkg::OPC_STORE);
    endfunction

    // retire the head once it has completed
    assign commit = head.valid && head.ready;

    // predicted not taken so a nonzero branch result is a mispredict
    assign flush = commit && head.is_branch && (head.value != '0);

    always_comb begin
        retire_out = '0;
        if (commit) begin
            retire_out.valid     = 1'b1;
            retire_out.tag       = head.tag;
            retire_out.reg_valid = writes_reg(head.opcode);
            retire_out.dest_reg  = writes_reg(head.opcode) ? head.dest_reg : `ZERO_REG;
            retire_out.value     = head.value;
            retire_out.mem_valid = writes_mem(head.opcode);
            // store value carries the effective address
            retire_out.mem_addr  = writes_mem(head.opcode) ? head.value : '0;
            retire_out.is_branch = head.is_branch;
            retire_out.flush     = flush;
        end
    end

endmodule

/* design/arch_regfile.sv */
`timescale 1ns/10ps

`include "rob_consts.svh"

module arch_regfile (
    input  logic                       clock,
    input  logic                       reset,

    // commit stream
    input  ooo_pkg::rob_retire_packet_t retire_in,

    // single read port
    input  ooo_pkg::reg_idx_t          read_reg,
    output ooo_pkg::word_t             read_value
);

    // committed architectural values
    ooo_pkg::word_t regs [`ARCH_REGS];

    // committed register write
    logic wr_en;

    //////////////////////////////
    // write at commit
    //////////////////////////////

    // x0 is never written
    assign wr_en = retire_in.valid && retire_in.reg_valid
                   && (retire_in.dest_reg != `ZERO_REG);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[retire_in.dest_reg] <= retire_in.value;
        end
    end

    //////////////////////////////
    // read
    //////////////////////////////

    // no bypass, a commit is visible the cycle after its edge
    assign read_value = (read_reg == `ZERO_REG) ? '0 : regs[read_reg];

endmodule

/* design/ooo_retire_top.sv */
`timescale 1ns/10ps

module ooo_retire_top (
    input  logic                         clock,
    input  logic                         reset,

    // dispatch
    input  ooo_pkg::dispatch_rob_packet_t dispatch_in,
    output ooo_pkg::rob_dispatch_packet_t dispatch_out,

    // completion
    input  ooo_pkg::cdb_rob_packet_t      cdb_in,

    // operand forwarding
    input  logic                         rs_read1,
    input  ooo_pkg::rob_tag_t            rs_tag1,
    input  logic                         rs_read2,
    input  ooo_pkg::rob_tag_t            rs_tag2,
    output ooo_pkg::word_t               rs_value1,
    output ooo_pkg::word_t               rs_value2,

    // architectural read
    input  ooo_pkg::reg_idx_t            arch_read_reg,
    output ooo_pkg::word_t               arch_read_value,

    // commit and status
    output ooo_pkg::rob_retire_packet_t   retire_out,
    output logic                         rob_full,
    output logic                         rob_empty
);

    // head slot toward retire
    ooo_pkg::rob_head_packet_t head;

    // retire decisions back into the rob
    logic commit;
    logic flush;

    reorder_buffer i_reorder_buffer (
        .clock        (clock),
        .reset        (reset),
        .dispatch_in  (dispatch_in),
        .dispatch_out (dispatch_out),
        .cdb_in       (cdb_in),
        .rs_read1     (rs_read1),
        .rs_tag1      (rs_tag1),
        .rs_read2     (rs_read2),
        .rs_tag2      (rs_tag2),
        .rs_value1    (rs_value1),
        .rs_value2    (rs_value2),
        .commit       (commit),
        .flush        (flush),
        .head         (head),
        .rob_full     (rob_full),
        .rob_empty    (rob_empty)
    );

    retire_control i_retire_control (
        .head       (head),
        .commit     (commit),
        .flush      (flush),
        .retire_out (retire_out)
    );

    // register file follows the retire packet directly
    arch_regfile i_arch_regfile (
        .clock      (clock),
        .reset      (reset),
        .retire_in  (retire_out),
        .read_reg   (arch_read_reg),
        .read_value (arch_read_value)
    );

endmodule

/* testbench/rob_tb.sv */
`timescale 1ns/10ps

`include "rob_consts.svh"

module rob_tb;

    //////////////////////////////
    // run length
    //////////////////////////////

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 3;
    localparam int FILL_CYCLES    = 48;
    localparam int FLUSH_CYCLES   = 8;
    localparam int DRAIN_LIMIT    = 200;
    localparam int RANDOM_CYCLES  = 3000;
    localparam int PLANNED_CYCLES = RESET_CYCLES + FILL_CYCLES + FLUSH_CYCLES
                                    + RANDOM_CYCLES + 3 * DRAIN_LIMIT;
    localparam int MARGIN_CYCLES  = 100;

    // one in-flight instruction as the model sees it
    typedef struct packed {
        ooo_pkg::rob_tag_t     tag;
        ooo_pkg::rv32_opcode_t opcode;
        ooo_pkg::reg_idx_t     dest_reg;
        logic                  is_branch;
        logic                  done;
        ooo_pkg::word_t        value;
    } model_entry_t;

    logic clock;
    logic reset;

    ooo_pkg::dispatch_rob_packet_t dispatch_in;
    ooo_pkg::rob_dispatch_packet_t dispatch_out;
    ooo_pkg::cdb_rob_packet_t      cdb_in;
    logic                          rs_read1;
    ooo_pkg::rob_tag_t             rs_tag1;
    logic                          rs_read2;
    ooo_pkg::rob_tag_t             rs_tag2;
    ooo_pkg::word_t                rs_value1;
    ooo_pkg::word_t                rs_value2;
    ooo_pkg::reg_idx_t             arch_read_reg;
    ooo_pkg::word_t                arch_read_value;
    ooo_pkg::rob_retire_packet_t   retire_out;
    logic                          rob_full;
    logic                          rob_empty;

    // model state updated at negedge for the coming edge
    model_entry_t      model_q [$];
    ooo_pkg::word_t    model_regs [`ARCH_REGS];
    ooo_pkg::rob_tag_t model_tail;
    logic              last_accept;
    ooo_pkg::reg_idx_t last_dest;
    logic [31:0]       lfsr_state;

    // event counts for the end of run
    int n_reg_writes;
    int n_zero_dest;
    int n_stores;
    int n_branch_nt;
    int n_flushes;
    int n_flush_refused;

    ooo_retire_top i_ooo_retire_top (
        .clock           (clock),
        .reset           (reset),
        .dispatch_in     (dispatch_in),
        .dispatch_out    (dispatch_out),
        .cdb_in          (cdb_in),
        .rs_read1        (rs_read1),
        .rs_tag1         (rs_tag1),
        .rs_read2        (rs_read2),
        .rs_tag2         (rs_tag2),
        .rs_value1       (rs_value1),
        .rs_value2       (rs_value2),
        .arch_read_reg   (arch_read_reg),
        .arch_read_value (arch_read_value),
        .retire_out      (retire_out),
        .rob_full        (rob_full),
        .rob_empty       (rob_empty)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    // fibonacci lfsr x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // tags run 1..31 and skip the null tag
    function automatic ooo_pkg::rob_tag_t next_tag(input ooo_pkg::rob_tag_t t);
        if (t == ooo_pkg::rob_tag_t'(`ROB_SZ - 1)) begin
            return ooo_pkg::rob_tag_t'(1);
        end
        return t + 1'b1;
    endfunction

    function automatic int find_entry(input ooo_pkg::rob_tag_t t);
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].tag == t) begin
                return i;
            end
        end
        return -1;
    endfunction

    // expected commit packet for a completed head
    function automatic ooo_pkg::rob_retire_packet_t expected_retire(input model_entry_t e);
        ooo_pkg::rob_retire_packet_t p;
        logic                        is_reg;
        logic                        is_store;
        is_reg = (e.opcode == ooo_pkg::OPC_LOAD) || (e.opcode == ooo_pkg::OPC_OP_IMM)
                 || (e.opcode == ooo_pkg::OPC_OP) || (e.opcode == ooo_pkg::OPC_JAL)
                 || (e.opcode == ooo_pkg::OPC_JALR) || (e.opcode == ooo_pkg::OPC_LUI)
                 || (e.opcode == ooo_pkg::OPC_AUIPC);
        is_store = (e.opcode == ooo_pkg::OPC_STORE);
        p = '0;
        p.valid     = 1'b1;
        p.tag       = e.tag;
        p.reg_valid = is_reg;
        p.dest_reg  = is_reg ? e.dest_reg : ooo_pkg::reg_idx_t'(0);
        p.value     = e.value;
        p.mem_valid = is_store;
        p.mem_addr  = is_store ? e.value : '0;
        p.is_branch = e.is_branch;
        // not-taken prediction so any nonzero branch result is a mispredict
        p.flush     = e.is_branch && (e.value != '0);
        return p;
    endfunction

    function automatic ooo_pkg::dispatch_rob_packet_t random_instruction();
        ooo_pkg::dispatch_rob_packet_t d;
        logic [31:0]                   sel;
        d = '0;
        sel = take_bits(4) % 12;
        case (sel)
            0:       d.opcode = ooo_pkg::OPC_LOAD;
            1:       d.opcode = ooo_pkg::OPC_STORE;
            2:       d.opcode = ooo_pkg::OPC_OP_IMM;
            3:       d.opcode = ooo_pkg::OPC_OP;
            4:       d.opcode = ooo_pkg::OPC_JAL;
            5:       d.opcode = ooo_pkg::OPC_JALR;
            6:       d.opcode = ooo_pkg::OPC_LUI;
            7:       d.opcode = ooo_pkg::OPC_AUIPC;
            // branches get extra weight
            default: d.opcode = ooo_pkg::OPC_BRANCH;
        endcase
        d.valid     = 1'b1;
        d.dest_reg  = ooo_pkg::reg_idx_t'(take_bits(5));
        d.is_branch = (d.opcode == ooo_pkg::OPC_BRANCH);
        return d;
    endfunction

    // mostly a live tag and otherwise any tag
    function automatic ooo_pkg::rob_tag_t pick_tag();
        if (model_q.size() > 0 && take_bits(1) != 0) begin
            return model_q[take_bits(5) % model_q.size()].tag;
        end
        return ooo_pkg::rob_tag_t'(take_bits(5));
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_retire(input string name, input ooo_pkg::rob_retire_packet_t got,
                                input ooo_pkg::rob_retire_packet_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure("retire packet mismatch");
        end
    endtask

    task automatic check_dispatch(input string name, input ooo_pkg::rob_dispatch_packet_t got,
                                  input ooo_pkg::rob_dispatch_packet_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure("dispatch answer mismatch");
        end
    endtask

    task automatic check_word(input string name, input ooo_pkg::word_t got,
                              input ooo_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure("data value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_with_failure("status flag mismatch");
        end
    endtask

    //////////////////////////////
    // compare process
    //////////////////////////////

    // outputs settle by negedge and the model then steps over the coming edge
    always @(negedge clock) begin : compare_cycle
        ooo_pkg::rob_retire_packet_t   exp_ret;
        ooo_pkg::rob_dispatch_packet_t exp_disp;
        model_entry_t                  e;
        logic                          accept;
        int                            idx;
        if (!reset) begin
            exp_ret = '0;
            if (model_q.size() > 0 && model_q[0].done) begin
                exp_ret = expected_retire(model_q[0]);
            end
            accept = dispatch_in.valid && (model_q.size() < `ROB_SZ - 1) && !exp_ret.flush;
            exp_disp.valid = accept;
            exp_disp.tag   = model_tail;

            check_retire("retire_out", retire_out, exp_ret);
            check_dispatch("dispatch_out", dispatch_out, exp_disp);
            check_bit("rob_full", rob_full, (model_q.size() == `ROB_SZ - 1) || exp_ret.flush);
            check_bit("rob_empty", rob_empty, model_q.size() == 0);
            check_word("arch_read_value", arch_read_value, model_regs[arch_read_reg]);

            // only completed live tags have a known forwarded value
            idx = find_entry(rs_tag1);
            if (!rs_read1) begin
                check_word("rs_value1", rs_value1, '0);
            end else if (idx >= 0 && model_q[idx].done) begin
                check_word("rs_value1", rs_value1, model_q[idx].value);
            end
            idx = find_entry(rs_tag2);
            if (!rs_read2) begin
                check_word("rs_value2", rs_value2, '0);
            end else if (idx >= 0 && model_q[idx].done) begin
                check_word("rs_value2", rs_value2, model_q[idx].value);
            end

            if (exp_ret.valid) begin
                e = model_q.pop_front();
                if (exp_ret.reg_valid && exp_ret.dest_reg != `ZERO_REG) begin
                    model_regs[exp_ret.dest_reg] = exp_ret.value;
                    last_dest = exp_ret.dest_reg;
                end
                n_reg_writes += exp_ret.reg_valid;
                n_zero_dest  += exp_ret.reg_valid && (exp_ret.dest_reg == `ZERO_REG);
                n_stores     += exp_ret.mem_valid;
                n_branch_nt  += exp_ret.is_branch && !exp_ret.flush;
            end

            if (cdb_in.valid) begin
                idx = find_entry(cdb_in.tag);
                if (idx < 0) begin
                    stop_with_failure("stimulus completed a tag that is not in flight");
                end
                e = model_q[idx];
                e.done  = 1'b1;
                e.value = cdb_in.value;
                model_q[idx] = e;
            end

            // mispredict drops every younger entry
            if (exp_ret.flush) begin
                model_q.delete();
                n_flushes++;
                n_flush_refused += dispatch_in.valid;
            end

            if (accept) begin
                e = '0;
                e.tag       = model_tail;
                e.opcode    = dispatch_in.opcode;
                e.dest_reg  = dispatch_in.dest_reg;
                e.is_branch = dispatch_in.is_branch;
                model_q.push_back(e);
                model_tail = next_tag(model_tail);
            end
            last_accept = accept;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // mode 0 is off, 1 random, 2 every cycle and 3 the oldest waiting entry (cdb only)
    task automatic drive_cycle(input int dispatch_mode, input int cdb_mode);
        ooo_pkg::dispatch_rob_packet_t d;
        ooo_pkg::cdb_rob_packet_t      c;
        int                            open_idx [$];
        int                            pick;
        @(posedge clock);
        // a refused instruction stays on the bus
        if (dispatch_in.valid && !last_accept) begin
            d = dispatch_in;
        end else begin
            d = '0;
            if (dispatch_mode == 2 || (dispatch_mode == 1 && take_bits(2) != 0)) begin
                d = random_instruction();
            end
        end
        dispatch_in <= d;

        for (int i = 0; i < model_q.size(); i++) begin
            if (!model_q[i].done) begin
                open_idx.push_back(i);
            end
        end
        pick = -1;
        if (open_idx.size() > 0) begin
            if (cdb_mode == 3) begin
                pick = open_idx[0];
            end else if (cdb_mode == 2 || (cdb_mode == 1 && take_bits(2) != 0)) begin
                pick = open_idx[take_bits(5) % open_idx.size()];
            end
        end
        c = '0;
        if (pick >= 0) begin
            c.valid = 1'b1;
            c.tag   = model_q[pick].tag;
            c.value = take_bits(32);
            // branches mostly resolve not taken and always do in oldest-first mode
            if (model_q[pick].is_branch && (cdb_mode == 3 || take_bits(2) != 0)) begin
                c.value = '0;
            end
        end
        cdb_in <= c;

        rs_read1 <= (take_bits(1) != 0);
        rs_tag1  <= pick_tag();
        rs_read2 <= (take_bits(1) != 0);
        rs_tag2  <= pick_tag();
        arch_read_reg <= (take_bits(1) != 0) ? last_dest : ooo_pkg::reg_idx_t'(take_bits(5));
    endtask

    // complete everything and wait for the empty flag
    task automatic drain_rob();
        int   cycles;
        logic drained;
        cycles  = 0;
        drained = 1'b0;
        while (!drained && cycles < DRAIN_LIMIT) begin
            drive_cycle(0, 2);
            @(negedge clock);
            drained = rob_empty && !dispatch_in.valid;
            cycles++;
        end
        if (!drained) begin
            stop_with_failure("the ROB did not drain within the cycle limit");
        end
    endtask

    // taken branch with a completed and a busy younger entry behind it
    task automatic flush_sequence();
        ooo_pkg::dispatch_rob_packet_t br;
        ooo_pkg::dispatch_rob_packet_t alu;
        ooo_pkg::cdb_rob_packet_t      c;
        ooo_pkg::rob_tag_t             br_tag;
        br = '0;
        br.valid     = 1'b1;
        br.opcode    = ooo_pkg::OPC_BRANCH;
        br.is_branch = 1'b1;
        alu = '0;
        alu.valid    = 1'b1;
        alu.opcode   = ooo_pkg::OPC_OP;
        alu.dest_reg = 5'd7;
        @(posedge clock);
        br_tag = model_tail;
        dispatch_in <= br;
        cdb_in      <= '0;
        @(posedge clock);
        dispatch_in <= alu;
        @(posedge clock);
        alu.dest_reg = 5'd8;
        dispatch_in <= alu;
        c = '0;
        c.valid = 1'b1;
        c.tag   = next_tag(br_tag);
        c.value = 32'h0000_0055;
        cdb_in <= c;
        @(posedge clock);
        alu.dest_reg = 5'd9;
        dispatch_in <= alu;
        c.tag   = br_tag;
        c.value = 32'h0000_0001;
        cdb_in <= c;
        @(posedge clock);
        // this one arrives in the flush cycle
        alu.dest_reg = 5'd10;
        dispatch_in <= alu;
        cdb_in      <= '0;
        @(negedge clock);
        check_bit("retire_out.flush", retire_out.flush, 1'b1);
        check_bit("dispatch_out.valid", dispatch_out.valid, 1'b0);
        @(negedge clock);
        check_bit("rob_empty", rob_empty, 1'b1);
    endtask

    initial begin
        clock         = 1'b0;
        reset         = 1'b1;
        dispatch_in   = '0;
        cdb_in        = '0;
        rs_read1      = 1'b0;
        rs_tag1       = '0;
        rs_read2      = 1'b0;
        rs_tag2       = '0;
        arch_read_reg = '0;
        lfsr_state    = 32'hc79d;
        model_tail    = ooo_pkg::rob_tag_t'(1);
        last_accept   = 1'b0;
        last_dest     = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        // fill to capacity and let one commit free a slot for tag 1
        repeat (`ROB_SZ) drive_cycle(2, 0);
        @(negedge clock);
        check_bit("rob_full", rob_full, 1'b1);
        check_bit("dispatch_out.valid", dispatch_out.valid, 1'b0);
        repeat (2) drive_cycle(2, 0);
        drive_cycle(2, 3);
        repeat (4) drive_cycle(2, 0);
        drain_rob();

        flush_sequence();
        drain_rob();

        repeat (RANDOM_CYCLES) drive_cycle(1, 1);
        drain_rob();

        if (n_reg_writes == 0 || n_zero_dest == 0 || n_stores == 0 || n_branch_nt == 0
            || n_flushes == 0 || n_flush_refused == 0) begin
            stop_with_failure("some commit kinds never occurred during the run");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        #((PLANNED_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        stop_with_failure("timeout: the run went past its planned number of cycles");
    end

endmodule

/* build.f */
+incdir+common
common/ooo_pkg.sv
rob/reorder_buffer.sv
design/retire_control.sv
design/arch_regfile.sv
design/ooo_retire_top.sv
testbench/rob_tb.sv

/* Bender.yml */
package:
  name: ooo_retire

export_include_dirs:
  - common

sources:
  - files:
      - common/ooo_pkg.sv
      - rob/reorder_buffer.sv
      - design/retire_control.sv
      - design/arch_regfile.sv
      - design/ooo_retire_top.sv

  - target: test
    files:
      - testbench/rob_tb.sv
